// ==== sources.f ====
rtl/cache_pkg.sv
rtl/cache_ram.sv
rtl/cache_fill_fsm.sv
rtl/cache_lookup.sv
rtl/cache_top.sv
testbench/cache_props.sv
testbench/memory_model.sv
testbench/cache_tb.sv

// ==== testbench/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

	localparam logic [word_w-1:0] pattern = 16'ha5c3; // memory word is its address xor this
	localparam int num_requests = 20;
	// a miss is one cycle plus eight words of up to four cycles each, two more for the gap
	localparam int max_cycles = num_requests * (1 + words_per_block * 4 + 2) + 50;

	// one entry of the request list
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic miss; // a fill is expected before the hit
	} req_case_t;

	logic clk;
	logic rst_n;
	cpu_req_t req;
	cpu_rsp_t rsp;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	int errors; // failed data checks
	int checks;
	int cycles; // clock edges since the start, for the timeout
	int words_seen; // strobes seen during the current request
	logic [addr_w-1:0] fill_base; // block base the memory addresses must start from
	string current; // name of the request in flight

	req_case_t cases [$];
	string names [$];

	cache_top #(
		.tag_depth(16),
		.data_depth(128)
	) i_cache_top (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.rsp(rsp),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	memory_model #(
		.pattern(pattern),
		.seed_init(19)
	) i_memory (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout, the request list did not finish within %0d cycles", max_cycles);
			$display("Test failures found");
			$finish;
		end
	end

	// word that memory holds for the 2-byte aligned address around this byte
	function automatic logic [word_w-1:0] expected_word(input logic [addr_w-1:0] addr);
		return {addr[addr_w-1:1], 1'b0} ^ pattern;
	endfunction

	task automatic check_value(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("[ERROR] %s %s: expected %h, actual %h", name, what, expected, actual);
		end
	endtask

	task automatic add_case(input logic [addr_w-1:0] addr, input logic miss, input string name);
		req_case_t c;
		c.addr = addr;
		c.miss = miss;
		cases.push_back(c);
		names.push_back(name);
	endtask

	// every strobe must carry the next word of the block, starting at the base
	always @(negedge clk) begin
		if (rst_n && mem_req.rd && mem_rsp.valid) begin
			check_value(current, "memory address", fill_base + addr_w'(2 * words_seen),
				mem_req.addr);
			words_seen++;
		end
	end

	// holds the request until stall falls, then checks the answer
	task automatic issue_request(input int n);
		req_case_t c;
		c = cases[n];
		current = names[n];
		@(posedge clk);
		req.valid <= 1'b1;
		req.addr <= c.addr;
		words_seen = 0;
		fill_base = {c.addr[addr_w-1:offset_w], {offset_w{1'b0}}}; // low 4 bits cleared
		@(negedge clk);
		check_value(current, "stall on request", c.miss, rsp.stall); // miss shows at once
		check_value(current, "read active on request", 1'b0, mem_req.rd);
		while (rsp.stall) begin
			@(negedge clk); // timeout catches a stall that never ends
		end
		check_value(current, "hit", 1'b1, rsp.hit);
		check_value(current, "data", expected_word(c.addr), rsp.data);
		check_value(current, "strobes", c.miss ? words_per_block : 0, words_seen);
		@(posedge clk);
		req.valid <= 1'b0; // one idle cycle before the next request
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		req = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		words_seen = 0;
		fill_base = '0;
		current = "after_reset";

		// index 3 holds tag 12 then 45, index 0 and index f are used for more eviction
		add_case(16'h1234, 1'b1, "cold_miss");
		add_case(16'h1230, 1'b0, "same_block_first_word");
		add_case(16'h123e, 1'b0, "same_block_last_word");
		add_case(16'h1237, 1'b0, "same_block_odd_byte");
		add_case(16'h4530, 1'b1, "other_tag_same_index");
		add_case(16'h453a, 1'b0, "other_tag_hit");
		add_case(16'h1234, 1'b1, "evicted_block_refill");
		add_case(16'h1238, 1'b0, "refilled_block_hit");
		add_case(16'h0000, 1'b1, "zero_tag_cold_miss");
		add_case(16'h000e, 1'b0, "zero_tag_hit");
		add_case(16'hfff2, 1'b1, "top_index_miss");
		add_case(16'hffff, 1'b0, "top_byte_hit");
		add_case(16'h00f0, 1'b1, "top_index_evict");
		add_case(16'hfff0, 1'b1, "top_index_refill");
		add_case(16'h1236, 1'b0, "index3_still_valid");
		add_case(16'h4538, 1'b1, "index3_evict_again");
		add_case(16'h0004, 1'b0, "index0_untouched");
		add_case(16'h8a5c, 1'b1, "index5_miss");
		add_case(16'h8a50, 1'b0, "index5_hit");
		add_case(16'h4532, 1'b0, "index3_new_tag_hit");

		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// no request yet, so no stall and no memory traffic
		@(negedge clk);
		check_value(current, "read active", 1'b0, mem_req.rd);
		check_value(current, "stall", 1'b0, rsp.stall);
		check_value(current, "hit", 1'b0, rsp.hit);

		for (int n = 0; n < cases.size(); n++) begin
			issue_request(n);
		end
		repeat (2) @(posedge clk);

		$display("checks %0d, errors %0d, property failures %0d", checks, errors,
			i_cache_top.i_props.failures);
		if (errors == 0 && i_cache_top.i_props.failures == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== testbench/memory_model.sv ====
`timescale 1ns/1ps

module memory_model import cache_pkg::*; #(
	parameter logic [word_w-1:0] pattern = 16'ha5c3, // every word is its address xor this
	parameter int seed_init = 19 // start value of the delay generator
) (
	input logic clk,
	input logic rst_n,
	input mem_req_t mem_req, // read-active level and word address from the cache
	output mem_rsp_t mem_rsp // data-valid strobe and word
);

	integer seed; // state of $random, advanced on every strobe
	logic [1:0] wait_q; // idle cycles left before the next strobe

	initial begin
		seed = seed_init;
		wait_q = '0;
	end

	// the strobe belongs to the address shown in the same cycle
	// so the word is formed straight from that address
	assign mem_rsp.valid = mem_req.rd && (wait_q == 2'd0);
	assign mem_rsp.data = mem_req.addr ^ pattern;

	always @(posedge clk) begin
		if (!rst_n) begin
			wait_q <= '0;
		end else if (mem_rsp.valid) begin
			// next word comes after 0 to 3 idle cycles
			wait_q <= 2'($random(seed));
		end else if (mem_req.rd && wait_q != 2'd0) begin
			wait_q <= wait_q - 2'd1; // only counts down while a read is active
		end
	end

	// between fills the last drawn delay stays put
	// it then delays the first word of the next fill

endmodule

// ==== testbench/cache_props.sv ====
`timescale 1ns/1ps

module cache_props import cache_pkg::*; (
	input logic clk,
	input logic rst_n,
	input cpu_rsp_t rsp, // hit, stall and word toward the processor
	input mem_req_t mem_req,
	input mem_rsp_t mem_rsp,
	input fill_ctrl_t fill, // fill machine state
	input logic miss,
	input logic tag_we
);

	int failures; // total of failed properties, read by the testbench at the end

	initial failures = 0;

	// the tag only goes in together with the last data word
	tag_with_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		tag_we |-> mem_rsp.valid)
		else begin
			$error("tag array written without a memory strobe");
			failures++;
		end

	// a miss starts the fill on the next edge and the processor stays stalled
	miss_starts_fill: assert property (@(posedge clk) disable iff (!rst_n)
		miss |=> (fill.busy && rsp.stall))
		else begin
			$error("miss did not start a stalled fill");
			failures++;
		end

	// stall holds for the whole fill, up to the cycle of the tag write
	stall_until_tag: assert property (@(posedge clk) disable iff (!rst_n)
		(fill.busy && !tag_we) |=> (fill.busy && rsp.stall))
		else begin
			$error("fill or stall ended before the tag write");
			failures++;
		end

	// stale tag entries during a fill must never produce a hit
	no_hit_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		fill.busy |-> !rsp.hit)
		else begin
			$error("hit reported while a fill is busy");
			failures++;
		end

	// memory may wait as long as it likes, the address must not move meanwhile
	addr_steady: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_req.rd && !mem_rsp.valid) |=> $stable(mem_req.addr))
		else begin
			$error("memory address changed without a strobe");
			failures++;
		end

endmodule

bind cache_top cache_props i_props (
	.clk(clk),
	.rst_n(rst_n),
	.rsp(rsp),
	.mem_req(mem_req),
	.mem_rsp(mem_rsp),
	.fill(fill),
	.miss(miss),
	.tag_we(tag_we)
);

// ==== rtl/cache_top.sv ====
`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
	parameter int tag_depth = 16, // one entry per set
	parameter int data_depth = 128 // sets times words per block
) (
	input logic clk,
	input logic rst_n,
	input cpu_req_t req, // processor read request
	output cpu_rsp_t rsp, // hit, stall and read word
	output mem_req_t mem_req, // read-active and address to memory
	input mem_rsp_t mem_rsp // data-valid strobe and word from memory
);

	localparam int tag_aw = $clog2(tag_depth);
	localparam int data_aw = $clog2(data_depth);

	fill_ctrl_t fill; // fill machine state seen by the lookup
	logic miss;
	logic [addr_w-1:0] mem_address;

	// tag array ports
	tag_entry_t tag_rd;
	tag_entry_t tag_wdata;
	logic tag_we;
	logic [tag_aw-1:0] tag_addr;

	// data array ports
	logic [word_w-1:0] data_rd;
	logic [word_w-1:0] data_wdata;
	logic data_we;
	logic [data_aw-1:0] data_waddr;
	logic [data_aw-1:0] data_raddr;

	// tag compare, hit and stall, and the write side of both arrays
	cache_lookup i_lookup (
		.req(req),
		.rsp(rsp),
		.fill(fill),
		.mem_rsp(mem_rsp),
		.miss(miss),
		.tag_rd(tag_rd),
		.tag_we(tag_we),
		.tag_addr(tag_addr),
		.tag_wdata(tag_wdata),
		.data_rd(data_rd),
		.data_we(data_we),
		.data_waddr(data_waddr),
		.data_raddr(data_raddr),
		.data_wdata(data_wdata)
	);

	// the missing address is the request address, held until the fill is over
	cache_fill_fsm i_fill (
		.clk(clk),
		.rst_n(rst_n),
		.miss(miss),
		.mem_valid(mem_rsp.valid),
		.miss_address(req.addr),
		.fill(fill),
		.mem_address(mem_address)
	);

	// valid bit and tag per set
	cache_ram #(
		.entry_t(tag_entry_t),
		.depth(tag_depth)
	) i_tag_ram (
		.clk(clk),
		.rst_n(rst_n),
		.we(tag_we),
		.waddr(tag_addr),
		.wdata(tag_wdata),
		.raddr(tag_addr), // single port, read and write share the index
		.rdata(tag_rd)
	);

	// 16-bit words, index and word select form the address
	cache_ram #(
		.entry_t(logic [word_w-1:0]),
		.depth(data_depth)
	) i_data_ram (
		.clk(clk),
		.rst_n(rst_n),
		.we(data_we),
		.waddr(data_waddr),
		.wdata(data_wdata),
		.raddr(data_raddr),
		.rdata(data_rd)
	);

	// memory reads for exactly as long as the fill machine is busy
	assign mem_req.rd = fill.busy;
	assign mem_req.addr = mem_address; // only moves after a strobe

endmodule

// ==== rtl/cache_lookup.sv ====
`timescale 1ns/1ps

module cache_lookup import cache_pkg::*; (
	input cpu_req_t req, // held by the processor while stalled
	output cpu_rsp_t rsp,
	input fill_ctrl_t fill, // state of the fill machine
	input mem_rsp_t mem_rsp, // strobe and word from memory
	output logic miss, // request needs a fill, only while idle
	input tag_entry_t tag_rd, // tag array entry at the request index
	output logic tag_we,
	output logic [index_w-1:0] tag_addr, // same address for read and write
	output tag_entry_t tag_wdata,
	input logic [word_w-1:0] data_rd, // data array word at data_raddr
	output logic data_we,
	output logic [index_w+word_sel_w-1:0] data_waddr,
	output logic [index_w+word_sel_w-1:0] data_raddr,
	output logic [word_w-1:0] data_wdata
);

	logic [tag_w-1:0] req_tag;
	logic [index_w-1:0] req_index;
	logic [word_sel_w-1:0] req_word; // word within the block, byte bit 0 ignored
	logic [word_sel_w-1:0] fill_word; // word the fill machine is fetching
	logic tag_match; // valid entry with an equal tag
	logic hit;

	// address split, tag on top, then index, then byte offset
	assign req_tag = req.addr[addr_w-1:index_w+offset_w];
	assign req_index = req.addr[index_w+offset_w-1:offset_w];
	assign req_word = req.addr[offset_w-1:1];
	assign fill_word = fill.offset[offset_w-1:1];

	// no tag reads happen during a fill that matter, stall is high throughout
	assign tag_addr = req_index;
	assign tag_match = tag_rd.valid & (tag_rd.tag == req_tag);

	// a fill in progress blocks hits, the tag entry may still be stale
	assign hit = req.valid & tag_match & ~fill.busy;

	// miss only while idle, the fill machine would ignore it otherwise
	assign miss = req.valid & ~tag_match & ~fill.busy;

	assign rsp.hit = hit;
	assign rsp.stall = miss | fill.busy; // falls on the cycle after the last strobe
	assign rsp.data = data_rd;

	// read port follows the request, even during a fill
	assign data_raddr = {req_index, req_word};

	// each strobe writes the word for the offset shown with it
	assign data_we = fill.write_data & mem_rsp.valid;
	assign data_waddr = {req_index, fill_word}; // request index is held during the fill
	assign data_wdata = mem_rsp.data;

	// the tag goes in on the same edge as the last data word
	assign tag_we = fill.write_tag;
	assign tag_wdata.valid = 1'b1;
	assign tag_wdata.tag = req_tag;

endmodule

// ==== rtl/cache_fill_fsm.sv ====
`timescale 1ns/1ps

module cache_fill_fsm import cache_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic miss, // lookup found no valid matching tag
	input logic mem_valid, // data-valid strobe from memory
	input logic [addr_w-1:0] miss_address, // address of the request that missed
	output fill_ctrl_t fill,
	output logic [addr_w-1:0] mem_address // block base plus current offset
);

	// offset of the last 2-byte word in a block, 14 for eight words
	localparam logic [offset_w-1:0] last_offset = offset_w'((words_per_block - 1) * 2);
	localparam logic [offset_w-1:0] offset_step = offset_w'(2); // one 16-bit word

	logic busy_q; // a block transfer is in progress
	logic [offset_w-1:0] offset_q; // byte offset of the word being requested
	logic [addr_w-1:0] base_q; // block-aligned address of the missing block
	logic at_last; // offset counter points at the final word
	logic last_word; // final word is being delivered in this cycle
	logic [addr_w-1:0] offset_ext; // offset widened for the address adder

	assign at_last = (offset_q == last_offset);

	// the fill ends on the strobe for the last word, not on reaching the offset
	// this way the final word is never written without data behind it
	assign last_word = busy_q & mem_valid & at_last;

	// zero extend, the offset never carries into the index
	assign offset_ext = {{(addr_w - offset_w){1'b0}}, offset_q};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			offset_q <= '0;
			base_q <= '0;
		end else if (!busy_q) begin
			// idle, a miss starts a fill on the next edge
			if (miss) begin
				busy_q <= 1'b1;
				base_q <= {miss_address[addr_w-1:offset_w], {offset_w{1'b0}}}; // drop the byte offset
			end
		end else if (mem_valid) begin
			if (at_last) begin
				// last word is written on this edge along with the tag
				busy_q <= 1'b0;
				offset_q <= '0;
				base_q <= '0;
			end else begin
				offset_q <= offset_q + offset_step; // next word once this one is in
			end
		end
	end

	// address only moves after a strobe, memory sees it steady while it waits
	assign mem_address = base_q + offset_ext;

	// data writes are allowed for the whole fill, lookup qualifies them with the strobe
	assign fill.busy = busy_q;
	assign fill.write_data = busy_q;
	assign fill.write_tag = last_word; // busy, last offset and strobe together
	assign fill.offset = offset_q;

endmodule

// ==== rtl/cache_ram.sv ====
`timescale 1ns/1ps

module cache_ram #(
	parameter type entry_t = logic [15:0], // stored payload, a tag entry or a data word
	parameter int depth = 16 // number of entries
) (
	input logic clk,
	input logic rst_n,
	input logic we, // write on the rising edge
	input logic [$clog2(depth)-1:0] waddr,
	input entry_t wdata,
	input logic [$clog2(depth)-1:0] raddr,
	output entry_t rdata // asynchronous read
);

	localparam int aw = $clog2(depth);

	entry_t mem [depth];

	// reset zeroes every entry, so all tag valid bits start low
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < depth; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// a hit is answered in the cycle of the request, so read is combinational
	// a write shows up on the read port only after the edge
	assign rdata = mem[raddr[aw-1:0]];

endmodule

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

	// byte address layout is tag | index | offset, 8 + 4 + 4 bits
	localparam int addr_w = 16;
	localparam int word_w = 16;
	localparam int offset_w = 4; // byte offset inside a 16-byte block
	localparam int index_w = 4; // 16 sets
	localparam int tag_w = addr_w - index_w - offset_w; // whatever is left above the index
	localparam int words_per_block = 8;

	// word select inside a block, taken from offset bits 3 to 1
	localparam int word_sel_w = $clog2(words_per_block);

	// one line of the tag array
	typedef struct packed {
		logic valid; // cleared by reset, set when a fill completes
		logic [tag_w-1:0] tag;
	} tag_entry_t;

	// processor read request, a level held for as long as stall is high
	typedef struct packed {
		logic valid;
		logic [addr_w-1:0] addr;
	} cpu_req_t;

	// answer to the processor
	typedef struct packed {
		logic hit; // data is good in this cycle
		logic stall; // miss or fill in progress
		logic [word_w-1:0] data;
	} cpu_rsp_t;

	// read request to memory
	typedef struct packed {
		logic rd; // read-active, the fill machine's busy level
		logic [addr_w-1:0] addr;
	} mem_req_t;

	// memory answer, data belongs to the address shown in the same cycle
	typedef struct packed {
		logic valid; // data-valid strobe
		logic [word_w-1:0] data;
	} mem_rsp_t;

	// control from the fill machine to the lookup
	typedef struct packed {
		logic busy;
		logic write_data; // data array may be written when a strobe comes
		logic write_tag; // last word is arriving, store tag and valid
		logic [offset_w-1:0] offset; // byte offset of the word being fetched
	} fill_ctrl_t;

endpackage
